//--- ex_isa_pkg.sv
package ex_isa_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    // Restoring divider walks one quotient bit per cycle
    localparam int DIV_STEPS = XLEN;
    localparam int DIV_CNT_W = $clog2(DIV_STEPS);

    typedef enum logic [4:0] {
        ADD, SUB, AND, OR, XOR, NOR,
        SLL, SRL, SRA, SLT, SLTU,
        LUI, PCADD,
        BEQ, BNE, BLT, BGE, JAL,
        MUL, MULH, MULHU,
        DIV, DIVU, MOD, MODU,
        LOAD, STORE
    } alu_op_e;

    // Which unit output lands in wdata
    typedef enum logic [2:0] {
        LOGIC, SHIFT, MOVE, ARITH, LINK, NONE
    } res_sel_e;

    typedef enum logic [1:0] {
        BYTE, HALF, WORD
    } mem_size_e;

    typedef enum logic [1:0] {
        MUL_OP_LO,
        MUL_OP_HI,
        MUL_OP_HIU
    } mul_op_e;

    typedef enum logic [1:0] {
        DIV_OP_DIV,
        DIV_OP_DIVU,
        DIV_OP_MOD,
        DIV_OP_MODU
    } div_op_e;

endpackage

//--- ex_pipe_pkg.sv
package ex_pipe_pkg;

    import ex_isa_pkg::*;

    //////////////////////////////
    // Dispatch -> EX
    //////////////////////////////

    typedef struct packed {
        logic                  valid;
        logic [XLEN-1:0]       pc;
        alu_op_e               aluop;
        res_sel_e              res_sel;
        logic [XLEN-1:0]       oprand1;
        logic [XLEN-1:0]       oprand2;
        logic [XLEN-1:0]       imm;
        logic                  reg_write_valid;
        logic [REG_ADDR_W-1:0] reg_write_addr;
        mem_size_e             mem_size;
        logic                  predicted_taken;
        // Raised before EX
        logic                  excp_in;
    } dispatch_ex_t;

    //////////////////////////////
    // EX -> MEM
    //////////////////////////////

    typedef struct packed {
        logic                  valid;
        logic [XLEN-1:0]       pc;
        alu_op_e               aluop;
        logic                  wreg;
        logic [REG_ADDR_W-1:0] waddr;
        logic [XLEN-1:0]       wdata;
        logic [XLEN-1:0]       mem_addr;
        logic [XLEN-1:0]       store_data;
        mem_size_e             mem_size;
        logic                  is_taken;
        logic                  excp;
        logic                  excp_ale;
    } ex_mem_t;

    // Back to dispatch for bypass
    typedef struct packed {
        logic                  wreg;
        logic                  data_ready;
        logic [REG_ADDR_W-1:0] waddr;
        logic [XLEN-1:0]       wdata;
    } data_forward_t;

endpackage

//--- ex_alu.sv
`timescale 1ns/1ps

module ex_alu
    import ex_isa_pkg::*;
(
    input  alu_op_e         aluop_i,
    input  logic [XLEN-1:0] pc_i,
    input  logic [XLEN-1:0] oprand1_i,
    input  logic [XLEN-1:0] oprand2_i,
    input  logic [XLEN-1:0] imm_i,
    output logic [XLEN-1:0] logic_o,
    output logic [XLEN-1:0] shift_o,
    output logic [XLEN-1:0] move_o,
    output logic [XLEN-1:0] compare_o,
    output logic            branch_taken_o,
    output logic [XLEN-1:0] branch_target_o
);

    logic [4:0] shamt;
    logic       signed_lt;
    logic       unsigned_lt;

    assign shamt       = oprand2_i[4:0];
    assign signed_lt   = $signed(oprand1_i) < $signed(oprand2_i);
    assign unsigned_lt = oprand1_i < oprand2_i;

    always_comb begin
        case (aluop_i)
            AND:     logic_o = oprand1_i & oprand2_i;
            OR:      logic_o = oprand1_i | oprand2_i;
            XOR:     logic_o = oprand1_i ^ oprand2_i;
            NOR:     logic_o = ~(oprand1_i | oprand2_i);
            default: logic_o = '0;
        endcase
    end

    always_comb begin
        case (aluop_i)
            SLL:     shift_o = oprand1_i << shamt;
            SRL:     shift_o = oprand1_i >> shamt;
            SRA:     shift_o = $signed(oprand1_i) >>> shamt;
            default: shift_o = '0;
        endcase
    end

    always_comb begin
        case (aluop_i)
            SLT:     compare_o = {{(XLEN-1){1'b0}}, signed_lt};
            SLTU:    compare_o = {{(XLEN-1){1'b0}}, unsigned_lt};
            default: compare_o = '0;
        endcase
    end

    // LUI arrives with the upper immediate already placed in oprand2
    always_comb begin
        case (aluop_i)
            LUI:     move_o = oprand2_i;
            PCADD:   move_o = pc_i + oprand2_i;
            default: move_o = '0;
        endcase
    end

    always_comb begin
        case (aluop_i)
            BEQ:     branch_taken_o = (oprand1_i == oprand2_i);
            BNE:     branch_taken_o = (oprand1_i != oprand2_i);
            BLT:     branch_taken_o = signed_lt;
            BGE:     branch_taken_o = ~signed_lt;
            JAL:     branch_taken_o = 1'b1;
            default: branch_taken_o = 1'b0;
        endcase
    end

    assign branch_target_o = pc_i + imm_i;

endmodule

//--- ex_mul_unit.sv
`timescale 1ns/1ps

module ex_mul_unit
    import ex_isa_pkg::*;
(
    input  logic            clk,
    input  logic            rst,
    input  logic            start_i,
    input  mul_op_e         op_i,
    input  logic [XLEN-1:0] rs1_i,
    input  logic [XLEN-1:0] rs2_i,
    output logic            busy_o,
    output logic            done_o,
    output logic [XLEN-1:0] result_o
);

    // One extra bit so signed and unsigned share a signed multiplier
    logic signed [XLEN:0]       a_q;
    logic signed [XLEN:0]       b_q;
    logic signed [2*XLEN+1:0]   prod_q;
    mul_op_e                    op_q;
    logic                       opnd_valid_q;
    logic                       prod_valid_q;
    logic                       sign_ext;

    assign sign_ext = (op_i == MUL_OP_HI);

    always_ff @(posedge clk) begin
        if (rst) begin
            opnd_valid_q <= 1'b0;
            prod_valid_q <= 1'b0;
            done_o       <= 1'b0;
        end else begin
            opnd_valid_q <= start_i;
            prod_valid_q <= opnd_valid_q;
            done_o       <= prod_valid_q;
        end
    end

    always_ff @(posedge clk) begin
        if (start_i) begin
            a_q  <= {sign_ext & rs1_i[XLEN-1], rs1_i};
            b_q  <= {sign_ext & rs2_i[XLEN-1], rs2_i};
            op_q <= op_i;
        end
        if (opnd_valid_q) begin
            prod_q <= a_q * b_q;
        end
        // Held until the next start
        if (prod_valid_q) begin
            result_o <= (op_q == MUL_OP_LO) ? prod_q[XLEN-1:0] : prod_q[2*XLEN-1:XLEN];
        end
    end

    assign busy_o = opnd_valid_q | prod_valid_q;

    a_no_start_when_busy: assert property (@(posedge clk) disable iff (rst)
        !(start_i && busy_o))
        else $error("multiplier started while busy");

endmodule

//--- ex_div_unit.sv
`timescale 1ns/1ps

module ex_div_unit
    import ex_isa_pkg::*;
(
    input  logic            clk,
    input  logic            rst,
    input  logic            start_i,
    input  div_op_e         op_i,
    input  logic [XLEN-1:0] dividend_i,
    input  logic [XLEN-1:0] divisor_i,
    output logic            busy_o,
    output logic            done_o,
    output logic [XLEN-1:0] quotient_o,
    output logic [XLEN-1:0] remainder_o
);

    typedef enum logic [1:0] {
        DIV_IDLE,
        DIV_ITER,
        DIV_FIX
    } div_state_e;

    div_state_e           state_q;
    logic [DIV_CNT_W-1:0] count_q;

    logic [XLEN-1:0] rem_q;
    logic [XLEN-1:0] quo_q;
    logic [XLEN-1:0] dsr_q;
    logic [XLEN-1:0] dividend_q;
    logic            neg_quo_q;
    logic            neg_rem_q;
    logic            dsr_zero_q;

    logic            is_signed;
    logic            dvd_neg;
    logic            dsr_neg;
    logic [XLEN:0]   shifted;
    logic [XLEN:0]   diff;

    assign is_signed = (op_i == DIV_OP_DIV) || (op_i == DIV_OP_MOD);
    assign dvd_neg   = is_signed & dividend_i[XLEN-1];
    assign dsr_neg   = is_signed & divisor_i[XLEN-1];

    // One restoring step
    assign shifted = {rem_q, quo_q[XLEN-1]};
    assign diff    = shifted - {1'b0, dsr_q};

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= DIV_IDLE;
            count_q <= '0;
            done_o  <= 1'b0;
        end else begin
            done_o <= 1'b0;
            case (state_q)
                DIV_IDLE: begin
                    if (start_i) begin
                        state_q <= DIV_ITER;
                        count_q <= '0;
                    end
                end
                DIV_ITER: begin
                    count_q <= count_q + 1'b1;
                    if (count_q == DIV_CNT_W'(DIV_STEPS - 1)) begin
                        state_q <= DIV_FIX;
                    end
                end
                default: begin
                    state_q <= DIV_IDLE;
                    done_o  <= 1'b1;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state_q)
            DIV_IDLE: begin
                if (start_i) begin
                    rem_q      <= '0;
                    quo_q      <= dvd_neg ? -dividend_i : dividend_i;
                    dsr_q      <= dsr_neg ? -divisor_i : divisor_i;
                    dividend_q <= dividend_i;
                    neg_quo_q  <= dvd_neg ^ dsr_neg;
                    neg_rem_q  <= dvd_neg;
                    dsr_zero_q <= (divisor_i == '0);
                end
            end
            DIV_ITER: begin
                if (!diff[XLEN]) begin
                    rem_q <= diff[XLEN-1:0];
                    quo_q <= {quo_q[XLEN-2:0], 1'b1};
                end else begin
                    rem_q <= shifted[XLEN-1:0];
                    quo_q <= {quo_q[XLEN-2:0], 1'b0};
                end
            end
            default: begin
                // Sign fix-up, zero divisor overrides
                quotient_o  <= dsr_zero_q ? '1 : (neg_quo_q ? -quo_q : quo_q);
                remainder_o <= dsr_zero_q ? dividend_q : (neg_rem_q ? -rem_q : rem_q);
            end
        endcase
    end

    assign busy_o = (state_q != DIV_IDLE);

    a_no_start_on_done: assert property (@(posedge clk) disable iff (rst)
        !(done_o && start_i))
        else $error("divider started in its done cycle");

endmodule

//--- ex_stage.sv
`timescale 1ns/1ps

module ex_stage
    import ex_isa_pkg::*;
    import ex_pipe_pkg::*;
(
    input  logic            clk,
    input  logic            rst,
    input  logic            flush_i,
    input  logic            clear_i,
    input  logic            advance_i,
    input  dispatch_ex_t    dispatch_i,
    output logic            advance_ready_o,
    output ex_mem_t         ex_o_buffer_o,
    output logic            redirect_o,
    output logic [XLEN-1:0] redirect_target_o,
    output data_forward_t   data_forward_o
);

    ex_mem_t         ex_o;
    logic [XLEN-1:0] logic_res;
    logic [XLEN-1:0] shift_res;
    logic [XLEN-1:0] move_res;
    logic [XLEN-1:0] compare_res;
    logic [XLEN-1:0] arith_res;
    logic [XLEN-1:0] mem_addr;
    logic            branch_taken;
    logic            capture;
    logic            is_load;
    logic            access_mem;
    logic            misaligned;

    logic            is_mul;
    logic            is_div;
    logic            is_mod;
    logic            is_muldiv;
    mul_op_e         mul_op;
    div_op_e         div_op;

    logic            mul_start;
    logic            mul_started_q;
    logic            mul_busy;
    logic            mul_done;
    logic [XLEN-1:0] mul_result;
    logic            div_start;
    logic            div_started_q;
    logic            div_busy;
    logic            div_done;
    logic [XLEN-1:0] quotient;
    logic [XLEN-1:0] remainder;
    logic            muldiv_finished_q;
    logic [XLEN-1:0] muldiv_result_q;

    ex_alu u_alu (
        .aluop_i        (dispatch_i.aluop),
        .pc_i           (dispatch_i.pc),
        .oprand1_i      (dispatch_i.oprand1),
        .oprand2_i      (dispatch_i.oprand2),
        .imm_i          (dispatch_i.imm),
        .logic_o        (logic_res),
        .shift_o        (shift_res),
        .move_o         (move_res),
        .compare_o      (compare_res),
        .branch_taken_o (branch_taken),
        .branch_target_o(redirect_target_o)
    );

    //////////////////////////////
    // Multi-cycle sequencing
    //////////////////////////////

    always_comb begin
        is_mul = 1'b0;
        is_div = 1'b0;
        is_mod = 1'b0;
        mul_op = MUL_OP_LO;
        div_op = DIV_OP_DIV;
        if (dispatch_i.valid) begin
            case (dispatch_i.aluop)
                MUL:   is_mul = 1'b1;
                MULH: begin
                    is_mul = 1'b1;
                    mul_op = MUL_OP_HI;
                end
                MULHU: begin
                    is_mul = 1'b1;
                    mul_op = MUL_OP_HIU;
                end
                DIV:   is_div = 1'b1;
                DIVU: begin
                    is_div = 1'b1;
                    div_op = DIV_OP_DIVU;
                end
                MOD: begin
                    is_div = 1'b1;
                    is_mod = 1'b1;
                    div_op = DIV_OP_MOD;
                end
                MODU: begin
                    is_div = 1'b1;
                    is_mod = 1'b1;
                    div_op = DIV_OP_MODU;
                end
                default: ;
            endcase
        end
    end

    assign is_muldiv       = is_mul | is_div;
    assign advance_ready_o = ~(is_muldiv & ~muldiv_finished_q);
    assign capture         = advance_i & advance_ready_o;

    // A unit left running by a flush must drain before the next start
    assign mul_start = is_mul & ~mul_started_q & ~mul_busy & ~mul_done & ~flush_i;
    assign div_start = is_div & ~div_started_q & ~div_busy & ~div_done & ~flush_i;

    always_ff @(posedge clk) begin
        if (rst || flush_i || capture) begin
            mul_started_q     <= 1'b0;
            div_started_q     <= 1'b0;
            muldiv_finished_q <= 1'b0;
        end else begin
            if (mul_start) begin
                mul_started_q <= 1'b1;
            end
            if (div_start) begin
                div_started_q <= 1'b1;
            end
            if ((mul_done && mul_started_q) || (div_done && div_started_q)) begin
                muldiv_finished_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (mul_done && mul_started_q) begin
            muldiv_result_q <= mul_result;
        end else if (div_done && div_started_q) begin
            muldiv_result_q <= is_mod ? remainder : quotient;
        end
    end

    ex_mul_unit u_mul_unit (
        .clk     (clk),
        .rst     (rst),
        .start_i (mul_start),
        .op_i    (mul_op),
        .rs1_i   (dispatch_i.oprand1),
        .rs2_i   (dispatch_i.oprand2),
        .busy_o  (mul_busy),
        .done_o  (mul_done),
        .result_o(mul_result)
    );

    ex_div_unit u_div_unit (
        .clk        (clk),
        .rst        (rst),
        .start_i    (div_start),
        .op_i       (div_op),
        .dividend_i (dispatch_i.oprand1),
        .divisor_i  (dispatch_i.oprand2),
        .busy_o     (div_busy),
        .done_o     (div_done),
        .quotient_o (quotient),
        .remainder_o(remainder)
    );

    //////////////////////////////
    // Result and memory record
    //////////////////////////////

    always_comb begin
        case (dispatch_i.aluop)
            ADD:                     arith_res = dispatch_i.oprand1 + dispatch_i.oprand2;
            SUB:                     arith_res = dispatch_i.oprand1 - dispatch_i.oprand2;
            SLT, SLTU:               arith_res = compare_res;
            MUL, MULH, MULHU:        arith_res = muldiv_result_q;
            DIV, DIVU, MOD, MODU:    arith_res = muldiv_result_q;
            default:                 arith_res = '0;
        endcase
    end

    assign mem_addr   = dispatch_i.oprand1 + dispatch_i.imm;
    assign is_load    = dispatch_i.valid & (dispatch_i.aluop == LOAD);
    assign access_mem = is_load | (dispatch_i.valid & (dispatch_i.aluop == STORE));

    always_comb begin
        case (dispatch_i.mem_size)
            BYTE:    misaligned = 1'b0;
            HALF:    misaligned = mem_addr[0];
            default: misaligned = |mem_addr[1:0];
        endcase
    end

    always_comb begin
        ex_o.valid      = dispatch_i.valid;
        ex_o.pc         = dispatch_i.pc;
        ex_o.aluop      = dispatch_i.aluop;
        ex_o.wreg       = dispatch_i.reg_write_valid;
        ex_o.waddr      = dispatch_i.reg_write_addr;
        ex_o.mem_addr   = mem_addr;
        ex_o.store_data = dispatch_i.oprand2;
        ex_o.mem_size   = dispatch_i.mem_size;
        ex_o.is_taken   = dispatch_i.valid & branch_taken;
        ex_o.excp_ale   = access_mem & misaligned;
        ex_o.excp       = dispatch_i.excp_in | ex_o.excp_ale;
        case (dispatch_i.res_sel)
            LOGIC:   ex_o.wdata = logic_res;
            SHIFT:   ex_o.wdata = shift_res;
            MOVE:    ex_o.wdata = move_res;
            ARITH:   ex_o.wdata = arith_res;
            LINK:    ex_o.wdata = dispatch_i.pc + 32'd4;
            default: ex_o.wdata = '0;
        endcase
    end

    // Only a mispredicted taken branch redirects
    assign redirect_o = dispatch_i.valid & branch_taken & ~dispatch_i.predicted_taken &
                        advance_i & ~flush_i;

    // Loads resolve in MEM
    assign data_forward_o.wreg       = dispatch_i.valid & dispatch_i.reg_write_valid;
    assign data_forward_o.data_ready = is_muldiv ? muldiv_finished_q : ~is_load;
    assign data_forward_o.waddr      = dispatch_i.reg_write_addr;
    assign data_forward_o.wdata      = ex_o.wdata;

    always_ff @(posedge clk) begin
        if (rst || flush_i || clear_i) begin
            ex_o_buffer_o <= '0;
        end else if (capture) begin
            ex_o_buffer_o <= ex_o;
        end
    end

    a_redirect_not_in_flush: assert property (@(posedge clk) disable iff (rst)
        redirect_o |-> (!flush_i && advance_ready_o))
        else $error("redirect raised during flush or stall");

    a_flush_empties_output: assert property (@(posedge clk) disable iff (rst)
        flush_i |=> !ex_o_buffer_o.valid)
        else $error("output record still valid after flush");

endmodule

//--- tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk_o,
    output logic rst_o
);

    // 20 ns period
    initial begin
        clk_o = 1'b0;
        forever #10 clk_o = ~clk_o;
    end

    initial begin
        rst_o = 1'b1;
        repeat (5) @(posedge clk_o);
        rst_o <= 1'b0;
    end

endmodule

//--- ex_stage_tb.sv
`timescale 1ns/1ps

module ex_stage_tb
    import ex_isa_pkg::*;
    import ex_pipe_pkg::*;
();

    localparam logic [1:0] KIND_PLAIN = 2'd0;
    localparam logic [1:0] KIND_FLUSH = 2'd1;
    localparam logic [1:0] KIND_CLEAR = 2'd2;
    localparam int RESET_CYCLES = 5;
    localparam int CYCLES_PER_ENTRY = 60;

    typedef struct packed {
        dispatch_ex_t    d;
        logic [XLEN-1:0] exp_wdata;
        logic [XLEN-1:0] exp_addr;
        logic            exp_ale;
        logic            exp_taken;
        logic            exp_redirect;
        logic [XLEN-1:0] exp_target;
        logic [1:0]      kind;
    } entry_t;

    logic            clk;
    logic            rst;
    logic            flush_i;
    logic            clear_i;
    logic            advance_i;
    dispatch_ex_t    dispatch_i;
    logic            advance_ready_o;
    ex_mem_t         ex_o_buffer_o;
    logic            redirect_o;
    logic [XLEN-1:0] redirect_target_o;
    data_forward_t   data_forward_o;

    entry_t entries[$];
    integer seed = 47726;
    int     pass_count = 0;
    int     fail_count = 0;
    int     cycle_count = 0;
    int     cycle_limit = 100000;

    tb_clock_gen u_clock_gen (
        .clk_o(clk),
        .rst_o(rst)
    );

    ex_stage UUT (
        .clk              (clk),
        .rst              (rst),
        .flush_i          (flush_i),
        .clear_i          (clear_i),
        .advance_i        (advance_i),
        .dispatch_i       (dispatch_i),
        .advance_ready_o  (advance_ready_o),
        .ex_o_buffer_o    (ex_o_buffer_o),
        .redirect_o       (redirect_o),
        .redirect_target_o(redirect_target_o),
        .data_forward_o   (data_forward_o)
    );

    //////////////////////////////
    // Reference model
    //////////////////////////////

    function automatic logic [XLEN-1:0] predict_wdata(input dispatch_ex_t d);
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        longint          sa;
        longint          sb;
        longint          sprod;
        logic [63:0]     uprod;
        logic [XLEN-1:0] r;
        a = d.oprand1;
        b = d.oprand2;
        sa = longint'($signed(a));
        sb = longint'($signed(b));
        sprod = sa * sb;
        uprod = {32'b0, a} * {32'b0, b};
        case (d.aluop)
            ADD:     r = a + b;
            SUB:     r = a - b;
            AND:     r = a & b;
            OR:      r = a | b;
            XOR:     r = a ^ b;
            NOR:     r = ~(a | b);
            SLL:     r = a << b[4:0];
            SRL:     r = a >> b[4:0];
            SRA:     r = 32'(sa >>> b[4:0]);
            SLT:     r = {31'b0, sa < sb};
            SLTU:    r = {31'b0, a < b};
            LUI:     r = b;
            PCADD:   r = d.pc + b;
            MUL:     r = uprod[31:0];
            MULH:    r = 32'(sprod >>> 32);
            MULHU:   r = uprod[63:32];
            DIV:     r = (b == '0) ? '1 : 32'(sa / sb);
            DIVU:    r = (b == '0) ? '1 : a / b;
            MOD:     r = (b == '0) ? a : 32'(sa % sb);
            MODU:    r = (b == '0) ? a : a % b;
            default: r = '0;
        endcase
        if (d.res_sel == LINK) begin
            r = d.pc + 32'd4;
        end else if (d.res_sel == NONE) begin
            r = '0;
        end
        return r;
    endfunction

    function automatic logic predict_taken(input dispatch_ex_t d);
        case (d.aluop)
            BEQ:     return d.oprand1 == d.oprand2;
            BNE:     return d.oprand1 != d.oprand2;
            BLT:     return $signed(d.oprand1) < $signed(d.oprand2);
            BGE:     return $signed(d.oprand1) >= $signed(d.oprand2);
            JAL:     return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    function automatic logic predict_ale(input dispatch_ex_t d);
        logic [XLEN-1:0] addr;
        addr = d.oprand1 + d.imm;
        if (d.aluop != LOAD && d.aluop != STORE) begin
            return 1'b0;
        end
        if (d.mem_size == HALF) begin
            return addr[0];
        end
        if (d.mem_size == WORD) begin
            return addr[1:0] != 2'b00;
        end
        return 1'b0;
    endfunction

    task automatic add_entry(input alu_op_e op, input res_sel_e sel,
                             input logic [XLEN-1:0] a, input logic [XLEN-1:0] b,
                             input logic [XLEN-1:0] imm, input mem_size_e size,
                             input logic pred, input logic [1:0] kind);
        entry_t e;
        e = '0;
        e.d.valid = 1'b1;
        e.d.pc = 32'h0000_1000 + 32'(entries.size() * 4);
        e.d.aluop = op;
        e.d.res_sel = sel;
        e.d.oprand1 = a;
        e.d.oprand2 = b;
        e.d.imm = imm;
        e.d.reg_write_valid = (sel != NONE) || (op == LOAD);
        e.d.reg_write_addr = 5'(entries.size() % 31 + 1);
        e.d.mem_size = size;
        e.d.predicted_taken = pred;
        // Upstream exception on every fourth entry
        e.d.excp_in = (entries.size() % 4 == 3);
        e.exp_wdata = predict_wdata(e.d);
        e.exp_addr = a + imm;
        e.exp_ale = predict_ale(e.d);
        e.exp_taken = predict_taken(e.d);
        e.exp_redirect = e.exp_taken && !pred;
        e.exp_target = e.d.pc + imm;
        e.kind = kind;
        entries.push_back(e);
    endtask

    function automatic int check_word(input string what, input int idx,
                                      input logic [XLEN-1:0] got, input logic [XLEN-1:0] exp);
        if (got !== exp) begin
            $display("ERROR at %0t: entry %0d %s is %h, expected %h", $time, idx, what, got, exp);
            return 1;
        end
        return 0;
    endfunction

    //////////////////////////////
    // Entry driver
    //////////////////////////////

    task automatic run_entry(input int idx);
        entry_t  e;
        alu_op_e op;
        int      errors;
        logic    saw_stall;
        logic    captured;
        logic    muldiv;
        e = entries[idx];
        op = e.d.aluop;
        errors = 0;
        saw_stall = 1'b0;
        captured = 1'b0;
        muldiv = op inside {MUL, MULH, MULHU, DIV, DIVU, MOD, MODU};
        dispatch_i <= e.d;
        advance_i <= 1'b1;
        if (e.kind == KIND_FLUSH) begin
            // Abandon the divide part way through
            repeat (6) @(posedge clk);
            flush_i <= 1'b1;
            advance_i <= 1'b0;
            dispatch_i <= '0;
            @(posedge clk);
            flush_i <= 1'b0;
            @(posedge clk);
            if (ex_o_buffer_o != '0) begin
                $display("ERROR at %0t: entry %0d output record not zero after flush",
                         $time, idx);
                errors++;
            end
        end else begin
            while (!captured) begin
                @(posedge clk);
                if (!advance_ready_o) begin
                    saw_stall = 1'b1;
                    if (data_forward_o.data_ready) begin
                        $display("ERROR at %0t: entry %0d forward ready before result",
                                 $time, idx);
                        errors++;
                    end
                end else begin
                    captured = 1'b1;
                    errors += check_word("redirect", idx, 32'(redirect_o),
                                         32'(e.exp_redirect));
                    if (e.exp_redirect) begin
                        errors += check_word("redirect target", idx, redirect_target_o,
                                             e.exp_target);
                    end
                    errors += check_word("forward ready", idx, 32'(data_forward_o.data_ready),
                                         32'(op != LOAD));
                    errors += check_word("forward waddr", idx, 32'(data_forward_o.waddr),
                                         32'(e.d.reg_write_addr));
                    errors += check_word("forward wreg", idx, 32'(data_forward_o.wreg),
                                         32'(e.d.reg_write_valid));
                    errors += check_word("forward wdata", idx, data_forward_o.wdata,
                                         e.exp_wdata);
                end
            end
            if (muldiv && !saw_stall) begin
                $display("Entry %0d: advance_ready_o never dropped for a multi-cycle op", idx);
                errors++;
            end
            if (!muldiv && saw_stall) begin
                $display("Entry %0d: a single-cycle op stalled the stage", idx);
                errors++;
            end
            dispatch_i <= '0;
            advance_i <= 1'b0;
            @(posedge clk);
            errors += check_word("valid", idx, 32'(ex_o_buffer_o.valid), 32'd1);
            errors += check_word("wdata", idx, ex_o_buffer_o.wdata, e.exp_wdata);
            errors += check_word("mem_addr", idx, ex_o_buffer_o.mem_addr, e.exp_addr);
            errors += check_word("excp_ale", idx, 32'(ex_o_buffer_o.excp_ale), 32'(e.exp_ale));
            errors += check_word("is_taken", idx, 32'(ex_o_buffer_o.is_taken),
                                 32'(e.exp_taken));
            errors += check_word("pc", idx, ex_o_buffer_o.pc, e.d.pc);
            errors += check_word("aluop", idx, 32'(ex_o_buffer_o.aluop), 32'(e.d.aluop));
            errors += check_word("wreg", idx, 32'(ex_o_buffer_o.wreg),
                                 32'(e.d.reg_write_valid));
            errors += check_word("waddr", idx, 32'(ex_o_buffer_o.waddr),
                                 32'(e.d.reg_write_addr));
            errors += check_word("store_data", idx, ex_o_buffer_o.store_data, e.d.oprand2);
            errors += check_word("mem_size", idx, 32'(ex_o_buffer_o.mem_size),
                                 32'(e.d.mem_size));
            errors += check_word("excp", idx, 32'(ex_o_buffer_o.excp),
                                 32'(e.d.excp_in | e.exp_ale));
            if (e.kind == KIND_CLEAR) begin
                clear_i <= 1'b1;
                @(posedge clk);
                clear_i <= 1'b0;
                @(posedge clk);
                if (ex_o_buffer_o != '0) begin
                    $display("ERROR at %0t: entry %0d output record not zero after clear",
                             $time, idx);
                    errors++;
                end
            end
        end
        if (errors == 0) begin
            pass_count++;
        end else begin
            fail_count++;
        end
        $display("Test %0d %s: %s", idx, op.name(), (errors == 0) ? "pass" : "fail");
    endtask

    //////////////////////////////
    // Table and main sequence
    //////////////////////////////

    initial begin
        alu_op_e md_ops [7];
        int      pick;
        md_ops = '{MUL, MULH, MULHU, DIV, DIVU, MOD, MODU};
        flush_i = 1'b0;
        clear_i = 1'b0;
        advance_i = 1'b0;
        dispatch_i = '0;

        add_entry(ADD,   ARITH, 32'h0000_0010, 32'h0000_0022, '0, BYTE, 1'b0, KIND_PLAIN);
        add_entry(SUB,   ARITH, 32'h0000_0003, 32'h0000_000a, '0, BYTE, 1'b0, KIND_PLAIN);
        add_entry(AND,   LOGIC, 32'hf0f0_ff00, 32'h0ff0_0ff0, '0, BYTE, 1'b0, KIND_PLAIN);
        add_entry(OR,    LOGIC, 32'hf0f0_ff00, 32'h0ff0_0ff0, '0, BYTE, 1'b0, KIND_PLAIN);
        add_entry(XOR,   LOGIC, 32'hf0f0_ff00, 32'h0ff0_0ff0, '0, BYTE, 1'b0, KIND_PLAIN);
        add_entry(NOR,   LOGIC, 32'hf0f0_ff00, 32'h0ff0_0ff0, '0, BYTE, 1'b0, KIND_CLEAR);
        add_entry(SLL,   SHIFT, 32'h0000_0003, 32'h0000_0021, '0, BYTE, 1'b0, KIND_PLAIN);
        add_entry(SRL,   SHIFT, 32'h8000_0000, 32'h0000_0004, '0, BYTE, 1'b0, KIND_PLAIN);
        add_entry(SRA,   SHIFT, 32'h8000_0000, 32'h0000_0004, '0, BYTE, 1'b0, KIND_PLAIN);
        add_entry(SLT,   ARITH, 32'hffff_ffff, 32'h0000_0001, '0, BYTE, 1'b0, KIND_PLAIN);
        add_entry(SLTU,  ARITH, 32'hffff_ffff, 32'h0000_0001, '0, BYTE, 1'b0, KIND_PLAIN);
        add_entry(LUI,   MOVE,  32'h0000_0000, 32'h1234_5000, '0, BYTE, 1'b0, KIND_PLAIN);
        add_entry(PCADD, MOVE,  32'h0000_0000, 32'h0000_0100, '0, BYTE, 1'b0, KIND_PLAIN);
        // Branches, with and without prediction
        add_entry(JAL,   LINK,  '0, '0, 32'h0000_0040, BYTE, 1'b0, KIND_PLAIN);
        add_entry(BEQ,   NONE,  32'd5, 32'd5, 32'hffff_fff0, BYTE, 1'b0, KIND_PLAIN);
        add_entry(BNE,   NONE,  32'd5, 32'd5, 32'h0000_0020, BYTE, 1'b0, KIND_PLAIN);
        add_entry(BLT,   NONE,  32'hffff_fffb, 32'd3, 32'h0000_0008, BYTE, 1'b1, KIND_PLAIN);
        add_entry(BGE,   NONE,  32'd2, 32'd7, 32'h0000_0008, BYTE, 1'b0, KIND_PLAIN);
        add_entry(LOAD,  NONE,  32'h0000_1000, '0, 32'd4, WORD, 1'b0, KIND_PLAIN);
        add_entry(LOAD,  NONE,  32'h0000_1000, '0, 32'd3, HALF, 1'b0, KIND_PLAIN);
        add_entry(STORE, NONE,  32'h0000_1000, 32'h55, 32'd6, WORD, 1'b0, KIND_PLAIN);
        add_entry(STORE, NONE,  32'h0000_1000, 32'h55, 32'd7, BYTE, 1'b0, KIND_PLAIN);
        add_entry(MUL,   ARITH, 32'hffff_fffd, 32'd7, '0, BYTE, 1'b0, KIND_PLAIN);
        add_entry(MULH,  ARITH, 32'h8000_0000, 32'd2, '0, BYTE, 1'b0, KIND_PLAIN);
        add_entry(MULHU, ARITH, 32'hffff_ffff, 32'hffff_ffff, '0, BYTE, 1'b0, KIND_PLAIN);
        add_entry(DIV,   ARITH, 32'hffff_fff9, 32'd2, '0, BYTE, 1'b0, KIND_PLAIN);
        add_entry(DIVU,  ARITH, 32'd7, 32'd0, '0, BYTE, 1'b0, KIND_PLAIN);
        add_entry(MOD,   ARITH, 32'hffff_fff9, 32'd2, '0, BYTE, 1'b0, KIND_PLAIN);
        add_entry(MODU,  ARITH, 32'd10, 32'd0, '0, BYTE, 1'b0, KIND_PLAIN);
        add_entry(DIV,   ARITH, 32'd1000, 32'd7, '0, BYTE, 1'b0, KIND_FLUSH);
        add_entry(DIVU,  ARITH, 32'd100, 32'd7, '0, BYTE, 1'b0, KIND_PLAIN);
        for (int i = 0; i < 10; i++) begin
            pick = int'($unsigned($random(seed)) % 7);
            add_entry(md_ops[pick], ARITH, $random(seed), $random(seed), '0, BYTE, 1'b0,
                      KIND_PLAIN);
        end
        cycle_limit = entries.size() * CYCLES_PER_ENTRY + RESET_CYCLES;

        @(posedge clk);
        while (rst) @(posedge clk);
        if (!advance_ready_o || redirect_o || ex_o_buffer_o != '0) begin
            $display("ERROR at %0t: stage not idle after reset", $time);
            fail_count++;
        end

        for (int i = 0; i < entries.size(); i++) begin
            run_entry(i);
        end

        $display("Summary: %0d tests passed, %0d tests failed", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    // Watchdog
    initial begin
        while (cycle_count <= cycle_limit) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

//--- ex_stage.f
ex_isa_pkg.sv
ex_pipe_pkg.sv
ex_alu.sv
ex_mul_unit.sv
ex_div_unit.sv
ex_stage.sv
tb_clock_gen.sv
ex_stage_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f ex_stage.f \
    --top-module ex_stage_tb \
    -o ex_stage_sim

output=$(./obj_dir/ex_stage_sim)
echo "$output"

if echo "$output" | grep -qF "*** TEST PASSED ***"; then
    exit 0
else
    exit 1
fi
